/* include/issue_settings.svh */
// issue stage settings
// widths of the decoded fields carried to execute and the issue slot count
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// instruction address (pc) width
`define ISSUE_INST_ADDR_WIDTH 32

// architectural register index
`define ISSUE_REG_ADDR_WIDTH 5

// decoded immediate
`define ISSUE_IMM_WIDTH 32

// reorder / commit tag
`define ISSUE_COMMIT_ID_WIDTH 3

// two-way issue, sizes grant and kill masks
`define ISSUE_SLOTS 2

`endif

/* logic/issue_pkg.sv */
// issue stage package
// field types shared by the duplicate filter, the slot registers and the checks
`default_nettype none

`include "issue_settings.svh"

package issue_pkg;

    // pc of a decoded instruction
    typedef logic [`ISSUE_INST_ADDR_WIDTH-1:0] inst_addr_t;

    // register file index
    typedef logic [`ISSUE_REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef logic [`ISSUE_IMM_WIDTH-1:0] imm_t;

    typedef logic [`ISSUE_COMMIT_ID_WIDTH-1:0] commit_id_t;

    // one bit per slot, bit 0 is slot 1
    typedef logic [`ISSUE_SLOTS-1:0] slot_mask_t;

endpackage

`default_nettype wire

/* logic/issue_dup_filter.sv */
// issue duplicate filter
// keeps the last address and grant seen by each slot and decides which slots
// go to execute as bubbles: flush, no grant from the hazard unit, or a repeat
// of an instruction that was already issued
`default_nettype none
`timescale 1ns/1ns

`include "issue_settings.svh"

module issue_dup_filter (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire issue_pkg::inst_addr_t slot1_addr_i,
    input  wire issue_pkg::inst_addr_t slot2_addr_i,
    input  wire issue_pkg::slot_mask_t issue_i,
    input  wire                        flush_i,
    input  wire                        stall_i,
    output issue_pkg::slot_mask_t      kill_o
);

    issue_pkg::inst_addr_t addr_in [`ISSUE_SLOTS];
    issue_pkg::inst_addr_t last_addr_q [`ISSUE_SLOTS];
    issue_pkg::slot_mask_t last_issued_q;
    issue_pkg::slot_mask_t dup;

    assign addr_in[0] = slot1_addr_i;
    assign addr_in[1] = slot2_addr_i;

    // repeat of the previous nonzero address that already got its grant
    always_comb begin
        for (int s = 0; s < `ISSUE_SLOTS; s++) begin
            dup[s] = (addr_in[s] != '0)
                  && (addr_in[s] == last_addr_q[s])
                  && last_issued_q[s];
        end
    end

    // flush kills both slots regardless of grant or history
    assign kill_o = {`ISSUE_SLOTS{flush_i}} | ~issue_i | dup;

    // history follows the decode side, frozen while dispatch stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `ISSUE_SLOTS; s++) begin
                last_addr_q[s] <= '0;
            end
            last_issued_q <= '0;
        end else if (!stall_i) begin
            if (flush_i) begin
                for (int s = 0; s < `ISSUE_SLOTS; s++) begin
                    last_addr_q[s] <= '0;
                end
                last_issued_q <= '0;
            end else begin
                for (int s = 0; s < `ISSUE_SLOTS; s++) begin
                    last_addr_q[s] <= addr_in[s];
                end
                // raw grant, so a repeating instruction stays suppressed
                last_issued_q <= issue_i;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/issue_slot_reg.sv */
// issue slot register
// holds one slot's decoded fields toward execute; a killed slot is loaded as
// an all-zero bubble and a dispatch stall freezes the whole slot
`default_nettype none
`timescale 1ns/1ns

module issue_slot_reg (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        stall_i,
    input  wire                        kill_i,

    // decoded fields from the filter stage
    input  wire issue_pkg::inst_addr_t addr_i,
    input  wire                        reg_we_i,
    input  wire issue_pkg::reg_addr_t  reg_waddr_i,
    input  wire issue_pkg::reg_addr_t  reg1_raddr_i,
    input  wire issue_pkg::reg_addr_t  reg2_raddr_i,
    input  wire issue_pkg::imm_t       imm_i,
    input  wire issue_pkg::commit_id_t commit_id_i,

    // toward execute
    output issue_pkg::inst_addr_t      addr_o,
    output logic                       reg_we_o,
    output issue_pkg::reg_addr_t       reg_waddr_o,
    output issue_pkg::reg_addr_t       reg1_raddr_o,
    output issue_pkg::reg_addr_t       reg2_raddr_o,
    output issue_pkg::imm_t            imm_o,
    output issue_pkg::commit_id_t      commit_id_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_o       <= '0;
            reg_we_o     <= 1'b0;
            reg_waddr_o  <= '0;
            reg1_raddr_o <= '0;
            reg2_raddr_o <= '0;
            imm_o        <= '0;
            commit_id_o  <= '0;
        end else if (!stall_i) begin
            if (kill_i) begin
                // bubble, nothing reaches the register file
                addr_o       <= '0;
                reg_we_o     <= 1'b0;
                reg_waddr_o  <= '0;
                reg1_raddr_o <= '0;
                reg2_raddr_o <= '0;
                imm_o        <= '0;
                commit_id_o  <= '0;
            end else begin
                addr_o       <= addr_i;
                reg_we_o     <= reg_we_i;
                reg_waddr_o  <= reg_waddr_i;
                reg1_raddr_o <= reg1_raddr_i;
                reg2_raddr_o <= reg2_raddr_i;
                imm_o        <= imm_i;
                commit_id_o  <= commit_id_i;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/issue_stage.sv */
// issue stage top
// register stage between decode and execute for the two-way core: the
// duplicate filter picks bubbles, one slot register per way carries the fields
`default_nettype none
`timescale 1ns/1ns

module issue_stage (
    input  wire                        clk,
    input  wire                        rst_n,

    // control from the pipeline controller and hazard unit
    input  wire                        flush_i,
    input  wire                        stall_i,
    input  wire issue_pkg::slot_mask_t issue_i,

    // slot 1 from decode
    input  wire issue_pkg::inst_addr_t slot1_addr_i,
    input  wire                        slot1_reg_we_i,
    input  wire issue_pkg::reg_addr_t  slot1_reg_waddr_i,
    input  wire issue_pkg::reg_addr_t  slot1_reg1_raddr_i,
    input  wire issue_pkg::reg_addr_t  slot1_reg2_raddr_i,
    input  wire issue_pkg::imm_t       slot1_imm_i,
    input  wire issue_pkg::commit_id_t slot1_commit_id_i,

    // slot 2 from decode
    input  wire issue_pkg::inst_addr_t slot2_addr_i,
    input  wire                        slot2_reg_we_i,
    input  wire issue_pkg::reg_addr_t  slot2_reg_waddr_i,
    input  wire issue_pkg::reg_addr_t  slot2_reg1_raddr_i,
    input  wire issue_pkg::reg_addr_t  slot2_reg2_raddr_i,
    input  wire issue_pkg::imm_t       slot2_imm_i,
    input  wire issue_pkg::commit_id_t slot2_commit_id_i,

    // slot 1 to execute
    output wire issue_pkg::inst_addr_t slot1_addr_o,
    output wire                        slot1_reg_we_o,
    output wire issue_pkg::reg_addr_t  slot1_reg_waddr_o,
    output wire issue_pkg::reg_addr_t  slot1_reg1_raddr_o,
    output wire issue_pkg::reg_addr_t  slot1_reg2_raddr_o,
    output wire issue_pkg::imm_t       slot1_imm_o,
    output wire issue_pkg::commit_id_t slot1_commit_id_o,

    // slot 2 to execute
    output wire issue_pkg::inst_addr_t slot2_addr_o,
    output wire                        slot2_reg_we_o,
    output wire issue_pkg::reg_addr_t  slot2_reg_waddr_o,
    output wire issue_pkg::reg_addr_t  slot2_reg1_raddr_o,
    output wire issue_pkg::reg_addr_t  slot2_reg2_raddr_o,
    output wire issue_pkg::imm_t       slot2_imm_o,
    output wire issue_pkg::commit_id_t slot2_commit_id_o
);

    // bubble request per slot, bit 0 is slot 1
    wire issue_pkg::slot_mask_t kill;

    issue_dup_filter u_filter (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot1_addr_i (slot1_addr_i),
        .slot2_addr_i (slot2_addr_i),
        .issue_i      (issue_i),
        .flush_i      (flush_i),
        .stall_i      (stall_i),
        .kill_o       (kill)
    );

    issue_slot_reg u_slot1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall_i),
        .kill_i       (kill[0]),
        .addr_i       (slot1_addr_i),
        .reg_we_i     (slot1_reg_we_i),
        .reg_waddr_i  (slot1_reg_waddr_i),
        .reg1_raddr_i (slot1_reg1_raddr_i),
        .reg2_raddr_i (slot1_reg2_raddr_i),
        .imm_i        (slot1_imm_i),
        .commit_id_i  (slot1_commit_id_i),
        .addr_o       (slot1_addr_o),
        .reg_we_o     (slot1_reg_we_o),
        .reg_waddr_o  (slot1_reg_waddr_o),
        .reg1_raddr_o (slot1_reg1_raddr_o),
        .reg2_raddr_o (slot1_reg2_raddr_o),
        .imm_o        (slot1_imm_o),
        .commit_id_o  (slot1_commit_id_o)
    );

    issue_slot_reg u_slot2 (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall_i),
        .kill_i       (kill[1]),
        .addr_i       (slot2_addr_i),
        .reg_we_i     (slot2_reg_we_i),
        .reg_waddr_i  (slot2_reg_waddr_i),
        .reg1_raddr_i (slot2_reg1_raddr_i),
        .reg2_raddr_i (slot2_reg2_raddr_i),
        .imm_i        (slot2_imm_i),
        .commit_id_i  (slot2_commit_id_i),
        .addr_o       (slot2_addr_o),
        .reg_we_o     (slot2_reg_we_o),
        .reg_waddr_o  (slot2_reg_waddr_o),
        .reg1_raddr_o (slot2_reg1_raddr_o),
        .reg2_raddr_o (slot2_reg2_raddr_o),
        .imm_o        (slot2_imm_o),
        .commit_id_o  (slot2_commit_id_o)
    );

endmodule

`default_nettype wire

/* tests/issue_stage_properties.sv */
// issue stage checks
// bound into the issue stage top; keeps its own duplicate history and checks
// bubbles, pass-through and stall hold on both slots at the falling edge
`default_nettype none
`timescale 1ns/1ns

`include "issue_settings.svh"

module issue_stage_properties #(
    parameter int FIELDS_W = `ISSUE_INST_ADDR_WIDTH + 1 + 3 * `ISSUE_REG_ADDR_WIDTH
                           + `ISSUE_IMM_WIDTH + `ISSUE_COMMIT_ID_WIDTH
) (
    input wire                        clk,
    input wire                        rst_n,
    input wire                        flush_i,
    input wire                        stall_i,
    input wire issue_pkg::slot_mask_t issue_i,
    // {addr, reg_we, waddr, raddr1, raddr2, imm, commit_id} per slot
    input wire [FIELDS_W-1:0]         slot1_in_i,
    input wire [FIELDS_W-1:0]         slot2_in_i,
    input wire [FIELDS_W-1:0]         slot1_out_i,
    input wire [FIELDS_W-1:0]         slot2_out_i
);

    logic [FIELDS_W-1:0]   in_now [`ISSUE_SLOTS];
    logic [FIELDS_W-1:0]   out_now [`ISSUE_SLOTS];
    logic [FIELDS_W-1:0]   in_q [`ISSUE_SLOTS];
    logic [FIELDS_W-1:0]   out_q [`ISSUE_SLOTS];
    issue_pkg::inst_addr_t addr_now [`ISSUE_SLOTS];
    issue_pkg::inst_addr_t hist_addr [`ISSUE_SLOTS];
    issue_pkg::slot_mask_t hist_issued;
    issue_pkg::slot_mask_t dup_now;
    issue_pkg::slot_mask_t issue_q;
    issue_pkg::slot_mask_t dup_q;
    logic                  stall_q;
    logic                  flush_q;
    logic                  live_q;
    int                    fail_count = 0;

    assign in_now[0]  = slot1_in_i;
    assign in_now[1]  = slot2_in_i;
    assign out_now[0] = slot1_out_i;
    assign out_now[1] = slot2_out_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `ISSUE_SLOTS; s++) begin
                hist_addr[s] <= '0;
                in_q[s]      <= '0;
                out_q[s]     <= '0;
            end
            hist_issued <= '0;
            issue_q     <= '0;
            dup_q       <= '0;
            stall_q     <= 1'b0;
            flush_q     <= 1'b0;
            live_q      <= 1'b0;
        end else begin
            // what this edge saw, compared at the next falling edge
            for (int s = 0; s < `ISSUE_SLOTS; s++) begin
                in_q[s]  <= in_now[s];
                out_q[s] <= out_now[s];
            end
            issue_q <= issue_i;
            dup_q   <= dup_now;
            stall_q <= stall_i;
            flush_q <= flush_i;
            live_q  <= 1'b1;
            // shadow history: cleared by flush, frozen by stall, raw grant kept
            if (!stall_i) begin
                for (int s = 0; s < `ISSUE_SLOTS; s++) begin
                    hist_addr[s] <= flush_i ? '0 : addr_now[s];
                end
                hist_issued <= flush_i ? '0 : issue_i;
            end
        end
    end

    for (genvar s = 0; s < `ISSUE_SLOTS; s++) begin : g_slot
        assign addr_now[s] = in_now[s][FIELDS_W-1 -: `ISSUE_INST_ADDR_WIDTH];
        assign dup_now[s]  = (addr_now[s] != '0) && (addr_now[s] == hist_addr[s])
                           && hist_issued[s];

        a_reset_zero: assert property (@(negedge clk) !live_q |-> out_now[s] == '0)
            else begin
                fail_count++;
                $error("ERROR %0t slot%0d outputs: got %h expected 0", $time, s + 1, out_now[s]);
            end

        a_pass: assert property (@(negedge clk) disable iff (!rst_n)
            live_q && !stall_q && !flush_q && issue_q[s] && !dup_q[s] |-> out_now[s] == in_q[s])
            else begin
                fail_count++;
                $error("ERROR %0t slot%0d outputs: got %h expected %h",
                       $time, s + 1, out_now[s], in_q[s]);
            end

        // flush, missing grant or a repeat all give a bubble
        a_bubble: assert property (@(negedge clk) disable iff (!rst_n)
            live_q && !stall_q && (flush_q || !issue_q[s] || dup_q[s]) |-> out_now[s] == '0)
            else begin
                fail_count++;
                $error("ERROR %0t slot%0d outputs: got %h expected 0", $time, s + 1, out_now[s]);
            end

        a_stall_hold: assert property (@(negedge clk) disable iff (!rst_n)
            live_q && stall_q |-> out_now[s] == out_q[s])
            else begin
                fail_count++;
                $error("ERROR %0t slot%0d outputs: got %h expected %h",
                       $time, s + 1, out_now[s], out_q[s]);
            end
    end

endmodule

bind issue_stage issue_stage_properties u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .stall_i     (stall_i),
    .issue_i     (issue_i),
    .slot1_in_i  ({slot1_addr_i, slot1_reg_we_i, slot1_reg_waddr_i, slot1_reg1_raddr_i,
                   slot1_reg2_raddr_i, slot1_imm_i, slot1_commit_id_i}),
    .slot2_in_i  ({slot2_addr_i, slot2_reg_we_i, slot2_reg_waddr_i, slot2_reg1_raddr_i,
                   slot2_reg2_raddr_i, slot2_imm_i, slot2_commit_id_i}),
    .slot1_out_i ({slot1_addr_o, slot1_reg_we_o, slot1_reg_waddr_o, slot1_reg1_raddr_o,
                   slot1_reg2_raddr_o, slot1_imm_o, slot1_commit_id_o}),
    .slot2_out_i ({slot2_addr_o, slot2_reg_we_o, slot2_reg_waddr_o, slot2_reg1_raddr_o,
                   slot2_reg2_raddr_o, slot2_imm_o, slot2_commit_id_o})
);

`default_nettype wire

/* tests/issue_stage_tb.sv */
// issue stage testbench
// drives both decode slots with a directed opening and random traffic; the
// bound checker compares, this module counts and reports the result
`default_nettype none
`timescale 1ns/1ns

`include "issue_settings.svh"

module issue_stage_tb;

    logic                  clk;
    logic                  rst_n;
    logic                  flush_i;
    logic                  stall_i;
    issue_pkg::slot_mask_t issue_i;
    issue_pkg::inst_addr_t slot1_addr_i, slot2_addr_i;
    logic                  slot1_reg_we_i, slot2_reg_we_i;
    issue_pkg::reg_addr_t  slot1_reg_waddr_i, slot2_reg_waddr_i;
    issue_pkg::reg_addr_t  slot1_reg1_raddr_i, slot2_reg1_raddr_i;
    issue_pkg::reg_addr_t  slot1_reg2_raddr_i, slot2_reg2_raddr_i;
    issue_pkg::imm_t       slot1_imm_i, slot2_imm_i;
    issue_pkg::commit_id_t slot1_commit_id_i, slot2_commit_id_i;

    wire issue_pkg::inst_addr_t slot1_addr_o, slot2_addr_o;
    wire                        slot1_reg_we_o, slot2_reg_we_o;
    wire issue_pkg::reg_addr_t  slot1_reg_waddr_o, slot2_reg_waddr_o;
    wire issue_pkg::reg_addr_t  slot1_reg1_raddr_o, slot2_reg1_raddr_o;
    wire issue_pkg::reg_addr_t  slot1_reg2_raddr_o, slot2_reg2_raddr_o;
    wire issue_pkg::imm_t       slot1_imm_o, slot2_imm_o;
    wire issue_pkg::commit_id_t slot1_commit_id_o, slot2_commit_id_o;

    // small pool so repeats are common, entry 0 is the zero address
    issue_pkg::inst_addr_t addr_pool [4];
    int                    wait_errors;

    issue_stage dut0 (.*);

    always #10 clk = ~clk;

    task automatic randomize_fields();
        slot1_reg_we_i     = 1'($urandom);
        slot1_reg_waddr_i  = issue_pkg::reg_addr_t'($urandom);
        slot1_reg1_raddr_i = issue_pkg::reg_addr_t'($urandom);
        slot1_reg2_raddr_i = issue_pkg::reg_addr_t'($urandom);
        slot1_imm_i        = issue_pkg::imm_t'($urandom);
        slot1_commit_id_i  = issue_pkg::commit_id_t'($urandom);
        slot2_reg_we_i     = 1'($urandom);
        slot2_reg_waddr_i  = issue_pkg::reg_addr_t'($urandom);
        slot2_reg1_raddr_i = issue_pkg::reg_addr_t'($urandom);
        slot2_reg2_raddr_i = issue_pkg::reg_addr_t'($urandom);
        slot2_imm_i        = issue_pkg::imm_t'($urandom);
        slot2_commit_id_i  = issue_pkg::commit_id_t'($urandom);
    endtask

    // new inputs land 2 ns after the rising edge
    task automatic drive_cycle(input issue_pkg::inst_addr_t a1, input issue_pkg::inst_addr_t a2,
                               input issue_pkg::slot_mask_t grant, input logic flush,
                               input logic stall);
        @(posedge clk);
        #2;
        slot1_addr_i = a1;
        slot2_addr_i = a2;
        issue_i      = grant;
        flush_i      = flush;
        stall_i      = stall;
        randomize_fields();
    endtask

    task automatic wait_slot1_addr(input issue_pkg::inst_addr_t expected, input int limit);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            @(negedge clk);
            seen = (slot1_addr_o == expected);
        end
        if (!seen) begin
            $display("timeout at %0t: slot 1 never showed address %h", $time, expected);
            wait_errors++;
        end
    endtask

    initial begin
        int total;
        void'($urandom(32'h3193));
        clk          = 1'b0;
        rst_n        = 1'b0;
        flush_i      = 1'b0;
        stall_i      = 1'b0;
        issue_i      = '0;
        slot1_addr_i = '0;
        slot2_addr_i = '0;
        randomize_fields();
        addr_pool[0] = 32'h0000_0000;
        addr_pool[1] = 32'h0000_1000;
        addr_pool[2] = 32'h0000_1004;
        addr_pool[3] = 32'h0000_2040;
        wait_errors  = 0;

        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // same pair three times, the repeats turn into bubbles
        repeat (3) drive_cycle(addr_pool[1], addr_pool[3], 2'b11, 1'b0, 1'b0);
        repeat (2) drive_cycle(addr_pool[0], addr_pool[0], 2'b11, 1'b0, 1'b0);
        drive_cycle(addr_pool[1], addr_pool[3], 2'b11, 1'b0, 1'b0);
        // flush clears history, same pair issues right after
        drive_cycle(addr_pool[1], addr_pool[3], 2'b11, 1'b1, 1'b0);
        drive_cycle(addr_pool[1], addr_pool[3], 2'b11, 1'b0, 1'b0);
        wait_slot1_addr(addr_pool[1], 4);

        // stall with and without flush holds a live pair and its history
        drive_cycle(addr_pool[2], addr_pool[1], 2'b11, 1'b0, 1'b0);
        drive_cycle(addr_pool[2], addr_pool[1], 2'b11, 1'b1, 1'b1);
        drive_cycle(addr_pool[2], addr_pool[1], 2'b11, 1'b0, 1'b1);
        drive_cycle(addr_pool[2], addr_pool[1], 2'b11, 1'b0, 1'b0);
        // no grant, then the same pair issues
        drive_cycle(addr_pool[3], addr_pool[2], 2'b00, 1'b0, 1'b0);
        drive_cycle(addr_pool[3], addr_pool[2], 2'b11, 1'b0, 1'b0);
        wait_slot1_addr(addr_pool[3], 4);

        repeat (400) begin
            drive_cycle(addr_pool[2'($urandom)], addr_pool[2'($urandom)],
                        issue_pkg::slot_mask_t'($urandom), ($urandom % 10) == 0,
                        ($urandom % 6) == 0);
        end
        drive_cycle(addr_pool[0], addr_pool[0], 2'b00, 1'b0, 1'b0);
        repeat (2) @(negedge clk);

        total = dut0.u_props.fail_count + wait_errors;
        $display("assertion failures: %0d, wait timeouts: %0d",
                 dut0.u_props.fail_count, wait_errors);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
logic/issue_pkg.sv
logic/issue_dup_filter.sv
logic/issue_slot_reg.sv
logic/issue_stage.sv
tests/issue_stage_properties.sv
tests/issue_stage_tb.sv

/* run.sh */
#!/bin/sh
# build and run the issue stage testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --assert --timing -f project.f --top-module issue_stage_tb \
    -o issue_stage_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/issue_stage_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
